//--- Bender.yml
package:
  name: video_capture

export_include_dirs:
  - .

sources:
  # videoCapture_settings.svh is picked up through the include directory
  - include_dirs:
      - .
    files:
      - videoPkg.sv
      - frameCapture.sv
      - lineRing.sv
      - outputScan.sv
      - captureTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - captureChecker.sv
      - captureTb.sv

//--- captureChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoCapture_settings.svh"

module captureChecker import videoPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  rgbPixel sourcePixel,
    input  beamPos  sourceBeam,
    input  logic    lineDoubler,
    input  rgbPixel outPixel,
    input  logic    outValid,
    input  beamPos  outBeam,
    input  logic    startTrigger,
    input  logic    rowEnd,
    input  int      rowTriggers,
    output int      errorCount,
    output int      checkCount
);

    typedef struct packed {
        logic    known;
        logic    valid;
        beamPos  beam;
        rgbPixel pixel;
    } expectedOut;

    rgbPixel    modelRing [`RING_WORDS];
    int         lineBase;
    int         triggerCount;
    logic       triggerDue;
    logic       triggerSeen;
    logic       scanRunning;
    beamPos     scanBeam;
    expectedOut stageOne;
    expectedOut stageTwo;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // ####################################################################
    // capture model, one sampled source position per call
    // ####################################################################
    task automatic applyCapture();
        int   x;
        int   y;
        int   hStart;
        int   hEnd;
        int   vStart;
        int   address;
        logic lineTaken;
        logic pixelTaken;
        x = sourceBeam.x;
        y = sourceBeam.y;
        if (lineDoubler) begin
            hStart = `H_CAPTURE_START_I;
            hEnd   = `H_CAPTURE_END_I;
            vStart = `V_CAPTURE_START_I;
            // lines 12 to 14 fall between the fields
            lineTaken = (y >= vStart && y < `V_FIELD_END_I)
                || (y >= `V_FIELD_RESUME_I + 1 && y < `V_CAPTURE_END_I);
        end else begin
            hStart    = `H_CAPTURE_START_P;
            hEnd      = `H_CAPTURE_END_P;
            vStart    = `V_CAPTURE_START_P;
            lineTaken = y >= vStart && y < `V_CAPTURE_END_P;
        end
        pixelTaken = lineTaken && x >= hStart && x < hEnd;
        address    = lineBase + x - hStart;
        triggerDue = pixelTaken && (y - vStart) < `RING_LINES
            && address == `TRIGGER_ADDRESS;
        if (pixelTaken) begin
            modelRing[address % `RING_WORDS] = sourcePixel;
        end
        if (x == hEnd) begin
            if (lineTaken && lineBase + `RING_LINE_LENGTH < `RING_WORDS) begin
                lineBase = lineBase + `RING_LINE_LENGTH;
            end else begin
                lineBase = 0;
            end
        end
    endtask

    // output raster model, restarted the cycle after an observed trigger
    task automatic advanceScan();
        if (triggerSeen) begin
            scanRunning = 1'b1;
            scanBeam    = '0;
        end else if (scanRunning) begin
            if (scanBeam.x == `OUT_H_TOTAL - 1) begin
                scanBeam.x = '0;
                scanBeam.y = (scanBeam.y == `OUT_V_TOTAL - 1) ? 12'd0 : scanBeam.y + 12'd1;
            end else begin
                scanBeam.x = scanBeam.x + 12'd1;
            end
        end
        triggerSeen    = startTrigger;
        stageTwo       = stageOne;
        stageOne.known = scanRunning;
        stageOne.valid = scanRunning && scanBeam.x < `OUT_ACTIVE_WIDTH
            && scanBeam.y < `OUT_ACTIVE_LINES;
        stageOne.beam  = scanBeam;
        stageOne.pixel = modelRing[(scanBeam.y * `RING_LINE_LENGTH + scanBeam.x) % `RING_WORDS];
    endtask

    // ####################################################################
    // per-cycle comparison
    // ####################################################################
    always @(posedge clock) begin
        if (reset) begin
            lineBase     = 0;
            triggerCount = 0;
            triggerDue   = 1'b0;
            triggerSeen  = 1'b0;
            scanRunning  = 1'b0;
            scanBeam     = '0;
            stageOne     = '0;
            stageTwo     = '0;
        end else begin
            compareField("startTrigger", 32'(triggerDue), 32'(startTrigger));
            compareField("outValid", 32'(stageTwo.valid), 32'(outValid));
            if (stageTwo.known) begin
                compareField("outBeam", 32'(stageTwo.beam), 32'(outBeam));
            end
            if (stageTwo.valid) begin
                compareField("outPixel", 32'(stageTwo.pixel), 32'(outPixel));
            end
            if (startTrigger === 1'b1) begin
                triggerCount++;
            end
            // one pulse per frame of the finished row
            if (rowEnd) begin
                compareField("startTrigger count", rowTriggers, triggerCount);
                triggerCount = 0;
            end
            applyCapture();
            advanceScan();
        end
    end

endmodule

`default_nettype wire

//--- captureTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoCapture_settings.svh"

module captureTb import videoPkg::*; ();

    localparam int ClockPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int SourceWidth = 50;
    localparam int SourceLines = 24;
    localparam int RowCount = 4;

    // one row per run with its expected trigger pulse count
    typedef struct packed {
        logic       doubler;
        logic [3:0] frames;
        logic       randomPattern;
        logic [3:0] triggers;
    } stimulusRow;

    logic       clock = 1'b0;
    logic       reset;
    rgbPixel    sourcePixel;
    beamPos     sourceBeam;
    logic       lineDoubler;
    rgbPixel    outPixel;
    logic       outValid;
    beamPos     outBeam;
    logic       startTrigger;
    logic       rowEnd;
    int         rowTriggers;
    int         errorCount;
    int         checkCount;
    int         cycleCount = 0;
    int         cycleLimit = 0;
    logic [15:0] lfsr;
    stimulusRow rows [RowCount];

    always #(ClockPeriod / 2) clock = ~clock;

    captureTop i_dut (
        .clock        (clock),
        .reset        (reset),
        .sourcePixel  (sourcePixel),
        .sourceBeam   (sourceBeam),
        .lineDoubler  (lineDoubler),
        .outPixel     (outPixel),
        .outValid     (outValid),
        .outBeam      (outBeam),
        .startTrigger (startTrigger)
    );

    captureChecker i_checker (
        .clock        (clock),
        .reset        (reset),
        .sourcePixel  (sourcePixel),
        .sourceBeam   (sourceBeam),
        .lineDoubler  (lineDoubler),
        .outPixel     (outPixel),
        .outValid     (outValid),
        .outBeam      (outBeam),
        .startTrigger (startTrigger),
        .rowEnd       (rowEnd),
        .rowTriggers  (rowTriggers),
        .errorCount   (errorCount),
        .checkCount   (checkCount)
    );

    // ####################################################################
    // pixel sources
    // ####################################################################
    function automatic logic [15:0] stepLfsr(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic randomColour(output rgbPixel colour);
        logic [23:0] bits;
        for (int i = 0; i < 24; i++) begin
            lfsr    = stepLfsr(lfsr);
            bits[i] = lfsr[0];
        end
        colour = bits;
    endtask

    function automatic rgbPixel rampColour(input int x, input int y);
        rgbPixel colour;
        colour.red   = 8'(x * 5);
        colour.green = 8'(y * 11);
        colour.blue  = 8'(x + y * 3);
        return colour;
    endfunction

    // ####################################################################
    // source raster for one row of the table
    // ####################################################################
    task automatic runRow(input stimulusRow row);
        rgbPixel colour;
        for (int frame = 0; frame < int'(row.frames); frame++) begin
            for (int y = 0; y < SourceLines; y++) begin
                for (int x = 0; x < SourceWidth; x++) begin
                    @(posedge clock);
                    #DriveDelay;
                    if (row.randomPattern) begin
                        randomColour(colour);
                    end else begin
                        colour = rampColour(x, y);
                    end
                    lineDoubler  = row.doubler;
                    sourceBeam.x = 12'(x);
                    sourceBeam.y = 12'(y);
                    sourcePixel  = colour;
                end
            end
        end
        @(posedge clock);
        #DriveDelay;
        rowEnd      = 1'b1;
        rowTriggers = int'(row.triggers);
        @(posedge clock);
        #DriveDelay;
        rowEnd = 1'b0;
    endtask

    task automatic finishRun(input logic timedOut);
        $display("checks %0d, errors %0d, timed out %0d", checkCount, errorCount, timedOut);
        if (timedOut || errorCount != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    endtask

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("the run did not end within %0d cycles", cycleLimit);
            finishRun(1'b1);
        end
    end

    initial begin
        int rowIndex;
        reset       = 1'b1;
        sourcePixel = '0;
        sourceBeam  = '0;
        lineDoubler = 1'b0;
        rowEnd      = 1'b0;
        rowTriggers = 0;
        lfsr        = 16'd9792;
        rows[0] = '{1'b0, 4'd2, 1'b0, 4'd2};
        rows[1] = '{1'b1, 4'd2, 1'b0, 4'd2};
        rows[2] = '{1'b0, 4'd3, 1'b1, 4'd3};
        rows[3] = '{1'b1, 4'd2, 1'b1, 4'd2};
        // 1200 cycles per source frame plus reset and row gaps
        cycleLimit = 600;
        for (rowIndex = 0; rowIndex < RowCount; rowIndex++) begin
            cycleLimit += int'(rows[rowIndex].frames) * SourceWidth * SourceLines;
        end
        repeat (10) @(posedge clock);
        #DriveDelay;
        reset = 1'b0;
        for (rowIndex = 0; rowIndex < RowCount; rowIndex++) begin
            runRow(rows[rowIndex]);
        end
        repeat (2) @(posedge clock);
        #DriveDelay;
        finishRun(1'b0);
    end

endmodule

`default_nettype wire

//--- captureTop.sv
`timescale 1ns/1ps
`default_nettype none

module captureTop import videoPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  rgbPixel sourcePixel,
    input  beamPos  sourceBeam,
    input  logic    lineDoubler,
    output rgbPixel outPixel,
    output logic    outValid,
    output beamPos  outBeam,
    output logic    startTrigger
);

    ringWrite ringWriteBus;
    ringRead  ringReadBus;
    rgbPixel  ringData;

    // ####################################################################
    // capture side
    // ####################################################################
    frameCapture i_frameCapture (
        .clock        (clock),
        .reset        (reset),
        .sourcePixel  (sourcePixel),
        .sourceBeam   (sourceBeam),
        .lineDoubler  (lineDoubler),
        .ringWriteOut (ringWriteBus),
        .startTrigger (startTrigger)
    );

    // shared line store
    lineRing i_lineRing (
        .clock       (clock),
        .ringWriteIn (ringWriteBus),
        .ringReadIn  (ringReadBus),
        .readData    (ringData)
    );

    // ####################################################################
    // output side, runs 64 words behind the writer
    // ####################################################################
    outputScan i_outputScan (
        .clock        (clock),
        .reset        (reset),
        .startTrigger (startTrigger),
        .ringReadOut  (ringReadBus),
        .readData     (ringData),
        .outPixel     (outPixel),
        .outValid     (outValid),
        .outBeam      (outBeam)
    );

endmodule

`default_nettype wire

//--- frameCapture.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoCapture_settings.svh"

module frameCapture import videoPkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  rgbPixel  sourcePixel,
    input  beamPos   sourceBeam,
    input  logic     lineDoubler,
    output ringWrite ringWriteOut,
    output logic     startTrigger
);

    localparam logic [`RING_ADDRESS_BITS-1:0] LineStep = `RING_LINE_LENGTH;
    localparam logic [`RING_ADDRESS_BITS-1:0] TriggerAddress = `TRIGGER_ADDRESS;
    localparam logic [11:0] LastLineBase = `RING_WORDS - `RING_LINE_LENGTH;

    logic [11:0] hStart;
    logic [11:0] hEnd;
    logic [11:0] vStart;
    logic [11:0] vEnd;

    logic        verticalCapture;
    logic        captureNow;
    logic        firstBuffer;
    logic [11:0] pixelOffset;
    logic [11:0] lineIndex;
    logic [11:0] fullAddress;

    logic [`RING_ADDRESS_BITS-1:0] lineBase;
    logic [`RING_ADDRESS_BITS-1:0] nextAddress;

    logic                          writeEnable;
    logic [`RING_ADDRESS_BITS-1:0] writeAddress;
    rgbPixel                       writeData;
    logic                          trigger;

    // ####################################################################
    // window selection
    // ####################################################################
    always_comb begin
        if (lineDoubler) begin
            hStart = 12'(`H_CAPTURE_START_I);
            hEnd   = 12'(`H_CAPTURE_END_I);
            vStart = 12'(`V_CAPTURE_START_I);
            vEnd   = 12'(`V_CAPTURE_END_I);
        end else begin
            hStart = 12'(`H_CAPTURE_START_P);
            hEnd   = 12'(`H_CAPTURE_END_P);
            vStart = 12'(`V_CAPTURE_START_P);
            vEnd   = 12'(`V_CAPTURE_END_P);
        end
    end

    // doubler skips the band between the two fields
    always_comb begin
        if (lineDoubler) begin
            verticalCapture = (sourceBeam.y < 12'(`V_FIELD_END_I))
                || (sourceBeam.y > 12'(`V_FIELD_RESUME_I) && sourceBeam.y < vEnd);
        end else begin
            verticalCapture = sourceBeam.y >= vStart && sourceBeam.y < vEnd;
        end
    end

    assign captureNow  = verticalCapture && sourceBeam.x >= hStart && sourceBeam.x < hEnd;
    assign pixelOffset = sourceBeam.x - hStart;
    assign fullAddress = 12'(lineBase) + pixelOffset;
    assign nextAddress = fullAddress[`RING_ADDRESS_BITS-1:0];
    assign lineIndex   = sourceBeam.y - vStart;
    assign firstBuffer = lineIndex < 12'(`RING_LINES);

    // ####################################################################
    // line base and registered write
    // ####################################################################
    always_ff @(posedge clock) begin
        if (reset) begin
            lineBase    <= '0;
            writeEnable <= 1'b0;
            trigger     <= 1'b0;
        end else begin
            // advance once per line, at the horizontal end
            if (sourceBeam.x == hEnd) begin
                if (verticalCapture && 12'(lineBase) < LastLineBase) begin
                    lineBase <= lineBase + LineStep;
                end else begin
                    lineBase <= '0;
                end
            end
            writeEnable <= captureNow;
            trigger     <= captureNow && firstBuffer && nextAddress == TriggerAddress;
        end
    end

    always_ff @(posedge clock) begin
        if (captureNow) begin
            writeAddress <= nextAddress;
            writeData    <= sourcePixel;
        end
    end

    assign ringWriteOut = '{enable: writeEnable, address: writeAddress, data: writeData};
    assign startTrigger = trigger;

    // line base plus offset must never run past the ring
    writeInRing: assert property (@(posedge clock) disable iff (reset)
        writeEnable |-> $past(fullAddress) < 12'(`RING_WORDS));

endmodule

`default_nettype wire

//--- lineRing.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoCapture_settings.svh"

module lineRing import videoPkg::*; (
    input  logic     clock,
    input  ringWrite ringWriteIn,
    input  ringRead  ringReadIn,
    output rgbPixel  readData
);

    // ####################################################################
    // pixel storage, RING_LINES lines of RING_LINE_LENGTH pixels
    // ####################################################################
    rgbPixel memory [`RING_WORDS];

    // write port
    always_ff @(posedge clock) begin
        if (ringWriteIn.enable) begin
            memory[ringWriteIn.address] <= ringWriteIn.data;
        end
    end

    // registered read port, old data on a same-address collision
    always_ff @(posedge clock) begin
        if (ringReadIn.enable) begin
            readData <= memory[ringReadIn.address];
        end
    end

endmodule

`default_nettype wire

//--- outputScan.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoCapture_settings.svh"

module outputScan import videoPkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    startTrigger,
    output ringRead ringReadOut,
    input  rgbPixel readData,
    output rgbPixel outPixel,
    output logic    outValid,
    output beamPos  outBeam
);

    localparam logic [11:0] LastX = `OUT_H_TOTAL - 1;
    localparam logic [11:0] LastY = `OUT_V_TOTAL - 1;
    localparam logic [11:0] ActiveWidth = `OUT_ACTIVE_WIDTH;
    localparam logic [11:0] ActiveLines = `OUT_ACTIVE_LINES;
    localparam logic [11:0] LineLength = `RING_LINE_LENGTH;

    logic        running;
    beamPos      scanBeam;
    logic        activeArea;
    logic [11:0] linearAddress;

    // first pipeline stage lines up with the ring read
    logic        stageValid;
    beamPos      stageBeam;

    // ####################################################################
    // output raster counters
    // ####################################################################
    always_ff @(posedge clock) begin
        if (reset) begin
            running  <= 1'b0;
            scanBeam <= '0;
        end else if (startTrigger) begin
            // restart on every trigger
            running  <= 1'b1;
            scanBeam <= '0;
        end else if (running) begin
            if (scanBeam.x == LastX) begin
                scanBeam.x <= '0;
                if (scanBeam.y == LastY) begin
                    scanBeam.y <= '0;
                end else begin
                    scanBeam.y <= scanBeam.y + 12'd1;
                end
            end else begin
                scanBeam.x <= scanBeam.x + 12'd1;
            end
        end
    end

    // ####################################################################
    // ring read addressing
    // ####################################################################
    assign activeArea = running && scanBeam.x < ActiveWidth && scanBeam.y < ActiveLines;

    // the ring size is a power of two so the modulo is a truncation
    assign linearAddress = scanBeam.y * LineLength + scanBeam.x;

    assign ringReadOut = '{
        enable:  activeArea,
        address: linearAddress[`RING_ADDRESS_BITS-1:0]
    };

    // ####################################################################
    // two-stage position pipeline to meet the read data
    // ####################################################################
    always_ff @(posedge clock) begin
        if (reset) begin
            stageValid <= 1'b0;
            outValid   <= 1'b0;
        end else begin
            stageValid <= activeArea;
            outValid   <= stageValid;
        end
    end

    always_ff @(posedge clock) begin
        stageBeam <= scanBeam;
        outBeam   <= stageBeam;
        outPixel  <= readData;
    end

    // nothing leaves the scanner while it is idle
    quietWhenIdle: assert property (@(posedge clock) disable iff (reset)
        outValid |-> running);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
videoPkg.sv
frameCapture.sv
lineRing.sv
outputScan.sv
captureTop.sv
captureChecker.sv
captureTb.sv

//--- videoCapture_settings.svh
`ifndef VIDEO_CAPTURE_SETTINGS_SVH
`define VIDEO_CAPTURE_SETTINGS_SVH

// ####################################################################
// line ring geometry
// ####################################################################

// pixels per stored line
`define RING_LINE_LENGTH 32
`define RING_LINES 4
`define RING_WORDS 128
`define RING_ADDRESS_BITS 7

// ####################################################################
// capture windows, in source beam coordinates
// ####################################################################

// progressive
`define H_CAPTURE_START_P 8
`define H_CAPTURE_END_P 40
`define V_CAPTURE_START_P 4
`define V_CAPTURE_END_P 20

// line doubler, both fields share one window
`define H_CAPTURE_START_I 10
`define H_CAPTURE_END_I 42
`define V_CAPTURE_START_I 0
`define V_CAPTURE_END_I 20

// band skipped between the fields
`define V_FIELD_END_I 12
`define V_FIELD_RESUME_I 14

// first word of ring line 2
`define TRIGGER_ADDRESS 64

// ####################################################################
// output raster
// ####################################################################
`define OUT_H_TOTAL 50
`define OUT_ACTIVE_WIDTH 32
`define OUT_ACTIVE_LINES 16
`define OUT_V_TOTAL 24

`endif

//--- videoPkg.sv
`default_nettype none

`include "videoCapture_settings.svh"

package videoPkg;

    // 24-bit colour, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbPixel;

    // beam counters of either raster
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } beamPos;

    // ring write port
    typedef struct packed {
        logic                          enable;
        logic [`RING_ADDRESS_BITS-1:0] address;
        rgbPixel                       data;
    } ringWrite;

    // ring read request, data returns one cycle later
    typedef struct packed {
        logic                          enable;
        logic [`RING_ADDRESS_BITS-1:0] address;
    } ringRead;

endpackage

`default_nettype wire
